//--- vlog.f
alloc_pkg.sv
mem_pkg.sv
alloc_bv_ram.sv
alloc_q_fifo.sv
alloc_bv_scan.sv
alloc_bv.sv
tb_alloc_bv.sv

//--- Bender.yml
package:
  name: alloc_bv

sources:
  # Packages first, then leaf blocks, then the top level
  - alloc_pkg.sv
  - mem_pkg.sv
  - alloc_bv_ram.sv
  - alloc_q_fifo.sv
  - alloc_bv_scan.sv
  - alloc_bv.sv

  # Directed testbench, top module tb_alloc_bv
  - target: test
    files:
      - tb_alloc_bv.sv

//--- tb_alloc_bv.sv
// Directed testbench for the bit-vector pointer allocator
// Clock, reset, watchdog, compare task and one task per test

`timescale 1ns/1ps
`default_nettype none

module tb_alloc_bv
    import alloc_pkg::*;
    import mem_pkg::*;
;

    localparam int ALLOC_Q_DEPTH   = 8;
    localparam int DEALLOC_Q_DEPTH = 8;
    localparam int NUM_PTRS        = 1 << PTR_WID;

    // Every pointer costs at most one 3-cycle operation
    // Factor 4 and a fixed margin on top
    localparam int WATCHDOG_CYCLES = NUM_PTRS * 3 * 4 + 1000;

    // Longest wait for one handshake
    // A full wrap of empty rows fits well inside
    localparam int HANDSHAKE_CYCLES = 200;

    // ----------------------------------------
    // DUT signals
    // ----------------------------------------

    logic clk;
    logic reset;
    logic en;
    logic init_done;
    logic alloc_req;
    logic alloc_rdy;
    ptr_t alloc_ptr;
    logic dealloc_req;
    logic dealloc_rdy;
    ptr_t dealloc_ptr;

    integer seed = 32'h862c_942d;

    // Pointers chosen for a test as list and as membership set
    ptr_t               picks[$];
    logic [NUM_PTRS-1:0] pick_set;

    alloc_bv #(
        .ALLOC_Q_DEPTH   (ALLOC_Q_DEPTH),
        .DEALLOC_Q_DEPTH (DEALLOC_Q_DEPTH)
    ) dut_i (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .init_done   (init_done),
        .alloc_req   (alloc_req),
        .alloc_rdy   (alloc_rdy),
        .alloc_ptr   (alloc_ptr),
        .dealloc_req (dealloc_req),
        .dealloc_rdy (dealloc_rdy),
        .dealloc_ptr (dealloc_ptr)
    );

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_run($sformatf("Timeout, run still busy after %0d cycles", WATCHDOG_CYCLES));
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped on error");
    endtask

    // Four-state compare so X or Z on an output counts as a mismatch
    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("FAILED %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // Take the queue head once alloc_rdy is seen on a falling edge
    task automatic take_ptr(output ptr_t p);
        int waited;
        waited = 0;
        while (!alloc_rdy) begin
            @(negedge clk);
            waited++;
            if (waited > HANDSHAKE_CYCLES) begin
                stop_run("No pointer became available on the allocate side");
            end
        end
        p         = alloc_ptr;
        alloc_req = 1'b1;
        @(negedge clk);
        alloc_req = 1'b0;
    endtask

    // Hand one pointer back once the queue has room
    task automatic give_ptr(input ptr_t p);
        int waited;
        waited = 0;
        while (!dealloc_rdy) begin
            @(negedge clk);
            waited++;
            if (waited > HANDSHAKE_CYCLES) begin
                stop_run("Deallocate side never became ready");
            end
        end
        dealloc_ptr = p;
        dealloc_req = 1'b1;
        @(negedge clk);
        dealloc_req = 1'b0;
    endtask

    // Distinct random pointers
    task automatic pick_ptrs(input int n);
        logic [31:0] r;
        ptr_t        p;
        picks.delete();
        pick_set = '0;
        while (picks.size() < n) begin
            r = $random(seed);
            p = r[PTR_WID-1:0];
            if (!pick_set[p]) begin
                pick_set[p] = 1'b1;
                picks.push_back(p);
            end
        end
    endtask

    // Each taken pointer must come from the set and show up only once
    task automatic take_picked(input string name, input int n);
        ptr_t p;
        for (int i = 0; i < n; i++) begin
            take_ptr(p);
            check(name, 1, pick_set[p]);
            pick_set[p] = 1'b0;
        end
    endtask

    task automatic expect_alloc_idle(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check(name, 0, alloc_rdy);
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    task automatic test_init();
        int cycles;
        check("reset_init_done", 0, init_done);
        check("reset_alloc_rdy", 0, alloc_rdy);
        check("reset_dealloc_rdy", 1, dealloc_rdy);
        cycles = 0;
        // No pointer may show up before the fill is done
        while (!init_done) begin
            check("init_alloc_rdy", 0, alloc_rdy);
            @(negedge clk);
            cycles++;
            if (cycles > NUM_ROWS + 4) begin
                stop_run("init_done did not rise after the RAM fill");
            end
        end
        cycles = 0;
        while (!alloc_rdy) begin
            @(negedge clk);
            cycles++;
            if (cycles > 16) begin
                stop_run("alloc_rdy did not follow init_done")
                ;
            end
        end
    endtask

    // Lowest free bit first and rows in sequence give 0 .. 255
    task automatic test_order();
        ptr_t p;
        // Queue fills up first so the scan has to stop and resume
        repeat (ALLOC_Q_DEPTH * 3 * 2) @(negedge clk);
        for (int i = 0; i < NUM_PTRS; i++) begin
            take_ptr(p);
            check("alloc_order", i, p);
        end
    endtask

    task automatic test_exhaustion();
        expect_alloc_idle("exhaustion", 200);
    endtask

    task automatic test_reuse();
        pick_ptrs(20);
        foreach (picks[i]) begin
            give_ptr(picks[i]);
        end
        take_picked("reuse_member", 20);
        expect_alloc_idle("reuse_idle", 150);
    endtask

    task automatic test_backpressure();
        en = 1'b0;
        // Let any operation in flight finish
        repeat (4) @(negedge clk);
        pick_ptrs(DEALLOC_Q_DEPTH);
        foreach (picks[i]) begin
            check("backpressure_rdy_high", 1, dealloc_rdy);
            dealloc_ptr = picks[i];
            dealloc_req = 1'b1;
            @(negedge clk);
        end
        dealloc_req = 1'b0;
        // Queue is full and nothing drains it
        repeat (20) begin
            check("backpressure_rdy_low", 0, dealloc_rdy);
            check("backpressure_alloc", 0, alloc_rdy);
            @(negedge clk);
        end
        en = 1'b1;
        take_picked("backpressure_member", DEALLOC_Q_DEPTH);
        expect_alloc_idle("backpressure_idle", 150);
        check("backpressure_drained", 1, dealloc_rdy);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        reset       = 1'b1;
        en          = 1'b1;
        alloc_req   = 1'b0;
        dealloc_req = 1'b0;
        dealloc_ptr = '0;
        pick_set    = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        test_init();
        test_order();
        test_exhaustion();
        test_reuse();
        test_backpressure();

        $display("Everything OK");
        $finish;
    end

endmodule : tb_alloc_bv

`default_nettype wire

//--- alloc_bv.sv
// Bit-vector pointer allocator top level
// RAM, scan engine, allocation and deallocation queues

`timescale 1ns/1ps
`default_nettype none

module alloc_bv
    import alloc_pkg::*;
    import mem_pkg::*;
#(
    // Burst size on the allocate side
    parameter int ALLOC_Q_DEPTH   = 8,
    // Burst size on the deallocate side
    parameter int DEALLOC_Q_DEPTH = 8
) (
    input  logic clk,
    input  logic reset,

    // Control and status
    input  logic en,
    output logic init_done,

    // Allocate interface
    input  logic alloc_req,
    output logic alloc_rdy,
    output ptr_t alloc_ptr,

    // Deallocate interface
    input  logic dealloc_req,
    output logic dealloc_rdy,
    input  ptr_t dealloc_ptr
);

    // ----------------------------------------
    // Signals
    // ----------------------------------------

    mem_wr_t   mem_wr;
    mem_rd_t   mem_rd;
    row_data_t rd_data;

    logic                               aq_push;
    ptr_t                               aq_ptr;
    logic                               aq_empty;
    logic [$clog2(ALLOC_Q_DEPTH+1)-1:0] aq_count;

    logic dq_pop;
    ptr_t dq_head;
    logic dq_empty;
    logic dq_full;

    // Handshakes, a transfer when req and rdy are both high
    assign alloc_rdy   = !aq_empty;
    assign dealloc_rdy = !dq_full;

    // ----------------------------------------
    // Bit-vector RAM
    // ----------------------------------------

    alloc_bv_ram ram_i (
        .clk       (clk),
        .reset     (reset),
        .wr        (mem_wr),
        .rd        (mem_rd),
        .rd_data   (rd_data),
        .init_done (init_done)
    );

    // ----------------------------------------
    // Scan and retire engine
    // ----------------------------------------

    alloc_bv_scan #(
        .ALLOC_Q_DEPTH (ALLOC_Q_DEPTH)
    ) scan_i (
        .clk       (clk),
        .reset     (reset),
        .en        (en),
        .init_done (init_done),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .rd_data   (rd_data),
        .aq_push   (aq_push),
        .aq_ptr    (aq_ptr),
        .aq_count  (aq_count),
        .dq_empty  (dq_empty),
        .dq_head   (dq_head),
        .dq_pop    (dq_pop)
    );

    // ----------------------------------------
    // Queues
    // ----------------------------------------

    // Filled by the scan, drained by requesters
    alloc_q_fifo #(
        .DEPTH  (ALLOC_Q_DEPTH),
        .data_t (ptr_t)
    ) alloc_q_i (
        .clk       (clk),
        .reset     (reset),
        .push      (aq_push),
        .push_data (aq_ptr),
        .pop       (alloc_req && alloc_rdy),
        .head      (alloc_ptr),
        .full      (),
        .empty     (aq_empty),
        .count     (aq_count)
    );

    // Filled by requesters, retired by the scan engine
    alloc_q_fifo #(
        .DEPTH  (DEALLOC_Q_DEPTH),
        .data_t (ptr_t)
    ) dealloc_q_i (
        .clk       (clk),
        .reset     (reset),
        .push      (dealloc_req && dealloc_rdy),
        .push_data (dealloc_ptr),
        .pop       (dq_pop),
        .head      (dq_head),
        .full      (dq_full),
        .empty     (dq_empty),
        .count     ()
    );

endmodule : alloc_bv

`default_nettype wire

//--- alloc_bv_scan.sv
// Scan and retire engine for the bit-vector allocator
// Read-modify-write of one RAM row per operation, retire before scan

`timescale 1ns/1ps
`default_nettype none

module alloc_bv_scan
    import alloc_pkg::*;
    import mem_pkg::*;
#(
    parameter int ALLOC_Q_DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 reset,

    // Control
    input  logic                                 en,
    input  logic                                 init_done,

    // RAM ports
    output mem_rd_t                              mem_rd,
    output mem_wr_t                              mem_wr,
    input  row_data_t                            rd_data,

    // Allocation queue, write side
    output logic                                 aq_push,
    output ptr_t                                 aq_ptr,
    input  logic [$clog2(ALLOC_Q_DEPTH+1)-1:0]   aq_count,

    // Deallocation queue, read side
    input  logic                                 dq_empty,
    input  ptr_t                                 dq_head,
    output logic                                 dq_pop
);

    localparam int COL_BITS = $bits(col_t);

    // ----------------------------------------
    // Declarations
    // ----------------------------------------

    typedef enum logic [1:0] {
        IDLE,
        READ,
        MODIFY
    } state_t;

    state_t    state;

    // Row the scan is working on
    row_addr_t scan_row;

    // Operation in flight
    logic      op_retire;
    row_addr_t op_row;
    col_t      op_col;
    row_data_t row_q;
    logic      wb_q;

    // Start decisions
    logic      aq_space;
    logic      start_retire;
    logic      start_scan;
    logic      start;

    // Lowest free bit of the returned row
    logic      found;
    col_t      low_col;

    // ----------------------------------------
    // Start of an operation
    // ----------------------------------------

    // Room for one more pointer in the allocation queue
    assign aq_space = (int'(aq_count) + 1) <= ALLOC_Q_DEPTH;

    // Retire wins over scan
    assign start_retire = (state == IDLE) && init_done && en && !dq_empty;
    assign start_scan   = (state == IDLE) && init_done && en && dq_empty && aq_space;
    assign start        = start_retire || start_scan;

    // Read issued in the start cycle
    always_comb begin
        mem_rd.en   = start;
        mem_rd.addr = start_retire ? dq_head[PTR_WID-1:COL_BITS] : scan_row;
    end

    // Head is captured below as the pop happens
    assign dq_pop = start_retire;

    // ----------------------------------------
    // Priority encoder
    // ----------------------------------------

    // Walk down so the lowest set bit is the last one kept
    always_comb begin
        found   = 1'b0;
        low_col = '0;
        for (int i = NUM_COLS - 1; i >= 0; i--) begin
            if (rd_data[i]) begin
                found   = 1'b1;
                low_col = col_t'(i);
            end
        end
    end

    // ----------------------------------------
    // State machine
    // ----------------------------------------

    // IDLE issues the read, READ takes the row, MODIFY writes back
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            scan_row <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= READ;
                    end
                end
                READ: begin
                    state <= MODIFY;
                end
                MODIFY: begin
                    state <= IDLE;
                    // Row used up, move on and wrap
                    if (!op_retire && !wb_q) begin
                        scan_row <= scan_row + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Operation payload
    always_ff @(posedge clk) begin
        if (start) begin
            op_retire <= start_retire;
            op_row    <= start_retire ? dq_head[PTR_WID-1:COL_BITS] : scan_row;
            op_col    <= dq_head[COL_BITS-1:0];
        end
        if (state == READ) begin
            if (op_retire) begin
                // Setting an already set bit leaves the row as it is
                row_q <= rd_data | (row_data_t'(1) << op_col);
                wb_q  <= 1'b1;
            end else begin
                row_q  <= rd_data & ~(row_data_t'(1) << low_col);
                op_col <= low_col;
                wb_q   <= found;
            end
        end
    end

    // ----------------------------------------
    // Write back and push
    // ----------------------------------------

    always_comb begin
        mem_wr.en   = (state == MODIFY) && wb_q;
        mem_wr.addr = op_row;
        mem_wr.data = row_q;
    end

    // Claimed pointer, built from row and column
    assign aq_push = (state == MODIFY) && !op_retire && wb_q;
    assign aq_ptr  = {op_row, op_col};

endmodule : alloc_bv_scan

`default_nettype wire

//--- alloc_q_fifo.sv
// Synchronous FIFO for the allocation and deallocation queues
// Circular buffer with occupancy count, head shown combinationally

`timescale 1ns/1ps
`default_nettype none

module alloc_q_fifo #(
    parameter int  DEPTH  = 8,
    parameter type data_t = logic
) (
    input  logic                         clk,
    input  logic                         reset,

    // Write side
    input  logic                         push,
    input  data_t                        push_data,

    // Read side
    input  logic                         pop,
    output data_t                        head,

    // Status
    output logic                         full,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int IDX_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [IDX_WID-1:0] idx_t;

    data_t buffer [DEPTH];

    idx_t  wr_idx;
    idx_t  rd_idx;
    logic  do_push;
    logic  do_pop;

    // Push on full and pop on empty are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == DEPTH);
    assign empty = (count == 0);
    assign head  = buffer[rd_idx];

    // ----------------------------------------
    // Indices and count
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            // Explicit wrap, DEPTH need not be a power of two
            if (do_push) begin
                wr_idx <= (wr_idx == idx_t'(DEPTH - 1)) ? '0 : wr_idx + 1'b1;
            end
            if (do_pop) begin
                rd_idx <= (rd_idx == idx_t'(DEPTH - 1)) ? '0 : rd_idx + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            buffer[wr_idx] <= push_data;
        end
    end

endmodule : alloc_q_fifo

`default_nettype wire

//--- alloc_bv_ram.sv
// Simple dual-port RAM holding the free-pointer bit vector
// Fills every row with ones after reset, then accepts writes

`timescale 1ns/1ps
`default_nettype none

module alloc_bv_ram
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // Write and read ports
    input  mem_wr_t   wr,
    input  mem_rd_t   rd,
    output row_data_t rd_data,

    // High once every row is filled
    output logic      init_done
);

    // ----------------------------------------
    // Init state machine
    // ----------------------------------------

    typedef enum logic {
        INIT,
        READY
    } state_t;

    state_t    state;
    row_addr_t init_row;

    // Storage
    row_data_t mem [NUM_ROWS];

    // Muxed write port
    logic      mem_wr_en;
    row_addr_t mem_wr_addr;
    row_data_t mem_wr_data;

    // One row per cycle, READY after the last row
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= INIT;
            init_row <= '0;
        end else begin
            if (state == INIT) begin
                init_row <= init_row + 1'b1;
                if (init_row == row_addr_t'(NUM_ROWS - 1)) begin
                    state <= READY;
                end
            end
        end
    end

    assign init_done = (state == READY);

    // ----------------------------------------
    // Write port
    // ----------------------------------------

    // Fill has the port during init, outside writes dropped
    always_comb begin
        if (state == INIT) begin
            mem_wr_en   = 1'b1;
            mem_wr_addr = init_row;
            mem_wr_data = '1;
        end else begin
            mem_wr_en   = wr.en;
            mem_wr_addr = wr.addr;
            mem_wr_data = wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            mem[mem_wr_addr] <= mem_wr_data;
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule : alloc_bv_ram

`default_nettype wire

//--- mem_pkg.sv
// Bit-vector RAM geometry, row address and data types
// Write and read request structs for the RAM ports

`default_nettype none

package mem_pkg;

    // ----------------------------------------
    // Geometry
    // ----------------------------------------

    // Free flags per row, one per pointer
    localparam int NUM_COLS = 16;

    // Number of rows, 16 x 16 covers all 256 pointers
    localparam int NUM_ROWS = 16;

    // Row index, same as the upper pointer bits
    typedef logic [3:0] row_addr_t;

    // One row of free flags, 1 marks a free pointer
    typedef logic [NUM_COLS-1:0] row_data_t;

    // ----------------------------------------
    // Port requests
    // ----------------------------------------

    // Single write request, 21 bits
    typedef struct packed {
        logic      en;
        row_addr_t addr;
        row_data_t data;
    } mem_wr_t;

    // Single read request, data returns a cycle later
    typedef struct packed {
        logic      en;
        row_addr_t addr;
    } mem_rd_t;

endpackage : mem_pkg

`default_nettype wire

//--- alloc_pkg.sv
// Pointer types shared by the allocator blocks
// Pointer width and column index type

`default_nettype none

package alloc_pkg;

    // ----------------------------------------
    // Pointer space
    // ----------------------------------------

    // Bits per pointer, 256 pointers in total
    localparam int PTR_WID = 8;

    // One pointer as handed out to a requester
    // Upper bits select the RAM row, lower bits the column
    typedef logic [PTR_WID-1:0] ptr_t;

    // ----------------------------------------
    // Row layout
    // ----------------------------------------

    // Bit position of a pointer inside its row
    // Matches the 16 free flags held per row
    typedef logic [3:0] col_t;

endpackage : alloc_pkg

`default_nettype wire
